//--- Makefile
TOP             ?= tb_unpacket
FILELIST        ?= filelist.f
SEED_LOG        ?= sim.log
BUILD_DIR       ?= obj_dir
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and search $(SEED_LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(SEED_LOG)"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(SEED_LOG)
	@grep -q "Simulation passed" $(SEED_LOG) || (echo "Test FAILED, see $(SEED_LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(SEED_LOG)

//--- common/unpacket_pkg.sv
package unpacket_pkg;

    // BRAM word and narrow port width
    localparam int word_width_p = 32;

    // BRAM address width that also covers the largest payload depth
    localparam int addr_width_p = 11;

    // Packet type in header bits 31 to 28
    typedef enum logic [3:0] {
        B2A_Z_BASIS_DETECTED     = 4'd1,
        B2A_X_BASIS_DETECTED     = 4'd2,
        B2A_ASK_PARITY           = 4'd3,
        B2A_VERIFICATION_HASHTAG = 4'd4
    } packet_type_e;

    // Length code in header bits 27 to 24
    // Short packets carry their depth in header bits 23 to 15
    typedef enum logic [3:0] {
        LEN_SHORT = 4'd1,
        LEN_514   = 4'd2,
        LEN_771   = 4'd3,
        LEN_1028  = 4'd4
    } length_code_e;

    // Destination port of a packet
    typedef enum logic [1:0] {
        ROUTE_NONE = 2'd0,
        ROUTE_Z    = 2'd1,
        ROUTE_X    = 2'd2,
        ROUTE_ER   = 2'd3
    } route_e;

    // Unpacker control states
    typedef enum logic [2:0] {
        IDLE          = 3'd0,
        READ_HEADER   = 3'd1,
        SET_PARAMETER = 3'd2,
        WRITE_PORTS   = 3'd3,
        UNPACK_DONE   = 3'd4,
        WAIT_NEXT     = 3'd5
    } unpack_state_e;

endpackage

//--- filelist.f
common/unpacket_pkg.sv
unpack/unpacket_fsm.sv
unpack/header_decoder.sv
unpack/bram_reader.sv
verilog/basis_router.sv
verilog/unpacket_top.sv
testbench/unpacket_assertions.sv
testbench/unpacket_checker.sv
testbench/tb_unpacket.sv

//--- testbench/tb_unpacket.sv
`timescale 1ns/1ns

module tb_unpacket;

    import unpacket_pkg::*;

    localparam int sift_full_count = 3;
    localparam int num_packets     = 10;
    localparam int seed            = 52;
    localparam int bram_size       = 2048;
    localparam int timeout_cycles  = num_packets * 2000 + 500;

    logic                      clk;
    logic                      rst_n;
    logic                      msg_ready;
    logic                      net_busy;
    logic                      sift_reset;
    logic                      rx_busy;
    logic                      sift_full;
    logic [addr_width_p-1:0]   bram_addr;
    logic [word_width_p-1:0]   bram_data = '0;
    logic                      z_wr_en;
    logic [word_width_p-1:0]   z_wr_data;
    logic                      x_wr_en;
    logic [2*word_width_p-1:0] x_wr_data;
    logic                      er_wr_en;
    logic [word_width_p-1:0]   er_wr_data;
    logic [word_width_p-1:0]   bram_mem [bram_size];
    int                        sift_model = 0;

    unpacket_top #(
        .sift_full_count (sift_full_count)
    ) unpacket_top_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .msg_ready  (msg_ready),
        .net_busy   (net_busy),
        .rx_busy    (rx_busy),
        .sift_reset (sift_reset),
        .sift_full  (sift_full),
        .bram_addr  (bram_addr),
        .bram_data  (bram_data),
        .z_wr_en    (z_wr_en),
        .z_wr_data  (z_wr_data),
        .x_wr_en    (x_wr_en),
        .x_wr_data  (x_wr_data),
        .er_wr_en   (er_wr_en),
        .er_wr_data (er_wr_data)
    );

    unpacket_checker port_checker_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .rx_busy    (rx_busy),
        .sift_full  (sift_full),
        .z_wr_en    (z_wr_en),
        .z_wr_data  (z_wr_data),
        .x_wr_en    (x_wr_en),
        .x_wr_data  (x_wr_data),
        .er_wr_en   (er_wr_en),
        .er_wr_data (er_wr_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Behavioral BRAM with one cycle read
    always @(posedge clk) begin
        bram_data <= bram_mem[bram_addr];
    end

    task automatic wait_cycles(input int cycles);
        repeat (cycles) @(posedge clk);
        #1;
    endtask

    function automatic logic [31:0] mem_word(input int addr);
        return bram_mem[addr_width_p'(addr)];
    endfunction

    function automatic int short_depth();
        return 1 + int'($urandom % 40);
    endfunction

    function automatic int payload_depth(input logic [31:0] header);
        case (header[27:24])
            LEN_SHORT: return int'(header[23:15]);
            LEN_514:   return 512;
            LEN_771:   return 768;
            default:   return 1024;
        endcase
    endfunction

    // Reference model of the port writes and sift_full for one packet
    function automatic void predict_writes(input logic [31:0] header);
        int depth;
        int i;
        depth = payload_depth(header);
        case (header[31:28])
            B2A_Z_BASIS_DETECTED: begin
                for (i = 1; i <= depth; i++) begin
                    port_checker_i.expect_z(mem_word(i));
                end
            end
            B2A_X_BASIS_DETECTED: begin
                // Earlier word in the upper half
                for (i = 1; i < depth; i += 2) begin
                    port_checker_i.expect_x({mem_word(i), mem_word(i + 1)});
                end
            end
            B2A_ASK_PARITY, B2A_VERIFICATION_HASHTAG: begin
                port_checker_i.expect_er(header);
                for (i = 1; i <= depth; i++) begin
                    port_checker_i.expect_er(mem_word(i));
                end
            end
            default: begin
                // Unknown types write nothing
            end
        endcase
        if ((header[31:28] == B2A_Z_BASIS_DETECTED || header[31:28] == B2A_X_BASIS_DETECTED)
            && sift_model < sift_full_count) begin
            sift_model++;
        end
        port_checker_i.expect_sift(sift_model == sift_full_count);
    endfunction

    task automatic run_packet(input logic [3:0] ptype, input logic [3:0] len,
                              input int depth, input int hold_cycles);
        logic [31:0] header;
        int          i;
        header = {ptype, len, 9'(depth), 15'($urandom)};
        bram_mem[0] = header;
        for (i = 1; i <= depth; i++) begin
            bram_mem[addr_width_p'(i)] = $urandom;
        end
        predict_writes(header);
        net_busy  = (hold_cycles > 0);
        msg_ready = 1'b1;
        repeat (hold_cycles) begin
            wait_cycles(1);
            if (rx_busy) begin
                port_checker_i.report_failure("message accepted while net_busy was high");
            end
        end
        net_busy = 1'b0;
        while (!rx_busy) wait_cycles(1);
        msg_ready = 1'b0;
        while (rx_busy) wait_cycles(1);
        wait_cycles(2);
    endtask

    task automatic pulse_sift_reset();
        sift_reset = 1'b1;
        wait_cycles(1);
        sift_reset = 1'b0;
        sift_model = 0;
    endtask

    initial begin
        int errors;
        int i;
        rst_n      = 1'b0;
        msg_ready  = 1'b0;
        net_busy   = 1'b0;
        sift_reset = 1'b0;
        void'($urandom(seed));
        for (i = 0; i < bram_size; i++) begin
            bram_mem[addr_width_p'(i)] = 32'hC0DE_0000 ^ 32'(i);
        end
        wait_cycles(4);
        rst_n = 1'b1;
        wait_cycles(1);
        if (rx_busy !== 1'b0 || sift_full !== 1'b0 || bram_addr !== '0
            || {z_wr_en, x_wr_en, er_wr_en} !== 3'b000) begin
            port_checker_i.report_failure("outputs not idle after reset");
        end
        run_packet(B2A_Z_BASIS_DETECTED, LEN_SHORT, short_depth(), 0);
        run_packet(B2A_Z_BASIS_DETECTED, LEN_SHORT, short_depth(), 5);
        run_packet(B2A_X_BASIS_DETECTED, LEN_SHORT, 2 * (1 + int'($urandom % 20)), 0);
        run_packet(B2A_X_BASIS_DETECTED, LEN_SHORT, 2 * (1 + int'($urandom % 20)), 0);
        run_packet(B2A_ASK_PARITY, LEN_SHORT, short_depth(), 0);
        run_packet(B2A_VERIFICATION_HASHTAG, LEN_SHORT, short_depth(), 0);
        pulse_sift_reset();
        run_packet(B2A_ASK_PARITY, LEN_SHORT, short_depth(), 0);
        run_packet(B2A_Z_BASIS_DETECTED, LEN_514, 512, 0);
        run_packet(4'hA, LEN_SHORT, short_depth(), 0);
        run_packet(B2A_X_BASIS_DETECTED, LEN_SHORT, 2 * (1 + int'($urandom % 20)), 3);
        wait_cycles(5);
        errors = port_checker_i.close_report();
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog sized from the packet count
    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("Timeout after %0d cycles, the run did not complete", timeout_cycles);
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- testbench/unpacket_assertions.sv
`timescale 1ns/1ns

module unpacket_assertions (
    input logic clk,
    input logic rst_n,
    input logic rx_busy,
    input logic sift_full,
    input logic param_clear,
    input logic z_wr_en,
    input logic x_wr_en,
    input logic er_wr_en
);

    // One port written per cycle at most
    one_write_at_a_time: assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0({z_wr_en, x_wr_en, er_wr_en})
    ) else $error("More than one write enable high in the same cycle");

    write_only_when_busy: assert property (
        @(posedge clk) disable iff (!rst_n) (z_wr_en || x_wr_en || er_wr_en) |-> rx_busy
    ) else $error("Port write while rx_busy is low");

    // Counter only moves on the packet end strobe
    sift_full_after_packet: assert property (
        @(posedge clk) disable iff (!rst_n) $rose(sift_full) |-> $past(param_clear)
    ) else $error("sift_full rose without a packet end in the previous cycle");

endmodule

bind unpacket_top unpacket_assertions unpacket_assertions_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .rx_busy     (rx_busy),
    .sift_full   (sift_full),
    .param_clear (param_clear),
    .z_wr_en     (z_wr_en),
    .x_wr_en     (x_wr_en),
    .er_wr_en    (er_wr_en)
);

//--- testbench/unpacket_checker.sv
`timescale 1ns/1ns

module unpacket_checker (
    input logic        clk,
    input logic        rst_n,
    input logic        rx_busy,
    input logic        sift_full,
    input logic        z_wr_en,
    input logic [31:0] z_wr_data,
    input logic        x_wr_en,
    input logic [63:0] x_wr_data,
    input logic        er_wr_en,
    input logic [31:0] er_wr_data
);

    // Expected writes per port with the oldest first
    logic [31:0] z_q[$];
    logic [63:0] x_q[$];
    logic [31:0] er_q[$];
    logic        sift_q[$];

    logic [31:0] want_word;
    logic [63:0] want_pair;
    logic        want_flag;
    logic        busy_q = 1'b0;
    int          mismatches = 0;
    int          unexpected = 0;
    int          others = 0;

    function void expect_z(input logic [31:0] value);
        z_q.push_back(value);
    endfunction

    function void expect_x(input logic [63:0] value);
        x_q.push_back(value);
    endfunction

    function void expect_er(input logic [31:0] value);
        er_q.push_back(value);
    endfunction

    function void expect_sift(input logic value);
        sift_q.push_back(value);
    endfunction

    function void report_failure(input string what);
        $display("Error at %0t: %s", $time, what);
        others++;
    endfunction

    // Registered outputs are settled by the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (z_wr_en) begin
                if (z_q.size() == 0) begin
                    $display("Unexpected write on the Z port, data %h", z_wr_data);
                    unexpected++;
                end else begin
                    want_word = z_q.pop_front();
                    if (want_word !== z_wr_data) begin
                        $display("Mismatch z_wr_data: expected %h, actual %h",
                                 want_word, z_wr_data);
                        mismatches++;
                    end
                end
            end
            if (x_wr_en) begin
                if (x_q.size() == 0) begin
                    $display("Unexpected write on the X port, data %h", x_wr_data);
                    unexpected++;
                end else begin
                    want_pair = x_q.pop_front();
                    if (want_pair !== x_wr_data) begin
                        $display("Mismatch x_wr_data: expected %h, actual %h",
                                 want_pair, x_wr_data);
                        mismatches++;
                    end
                end
            end
            if (er_wr_en) begin
                if (er_q.size() == 0) begin
                    $display("Unexpected write on the ER port, data %h", er_wr_data);
                    unexpected++;
                end else begin
                    want_word = er_q.pop_front();
                    if (want_word !== er_wr_data) begin
                        $display("Mismatch er_wr_data: expected %h, actual %h",
                                 want_word, er_wr_data);
                        mismatches++;
                    end
                end
            end
            // End of a message with the sift counter already updated
            if (busy_q && !rx_busy) begin
                if (sift_q.size() == 0) begin
                    report_failure("a message finished that the stimulus never sent");
                end else begin
                    want_flag = sift_q.pop_front();
                    if (want_flag !== sift_full) begin
                        $display("Mismatch sift_full: expected %h, actual %h", want_flag, sift_full);
                        mismatches++;
                    end
                end
            end
            busy_q = rx_busy;
        end
    end

    function int close_report();
        int missing;
        missing = z_q.size() + x_q.size() + er_q.size() + sift_q.size();
        if (missing != 0) begin
            $display("Expected results never seen: %0d Z, %0d X, %0d ER, %0d sift_full",
                     z_q.size(), x_q.size(), er_q.size(), sift_q.size());
        end
        $display("Errors: %0d mismatched, %0d unexpected, %0d missing, %0d other",
                 mismatches, unexpected, missing, others);
        return mismatches + unexpected + missing + others;
    endfunction

endmodule

//--- unpack/bram_reader.sv
`timescale 1ns/1ns

module bram_reader (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  read_en,
    input  logic                                  param_clear,
    input  logic [unpacket_pkg::addr_width_p-1:0] real_depth,
    input  logic                                  include_header,
    output logic [unpacket_pkg::addr_width_p-1:0] bram_addr,
    input  logic [unpacket_pkg::word_width_p-1:0] bram_data,
    output logic [unpacket_pkg::word_width_p-1:0] bram_word,
    output logic                                  word_valid,
    output logic [unpacket_pkg::word_width_p-1:0] word_data,
    output logic                                  write_done
);

    import unpacket_pkg::*;

    // Address register plus BRAM latency plus output register
    localparam logic [addr_width_p-1:0] read_lag = addr_width_p'(3);

    logic [addr_width_p-1:0] read_cnt;
    logic [addr_width_p-1:0] first_cnt;
    logic [addr_width_p-1:0] last_cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            read_cnt <= '0;
        end else if (param_clear) begin
            read_cnt <= '0;
        end else if (read_en) begin
            read_cnt <= read_cnt + addr_width_p'(1);
        end
    end

    // Addresses 0 to real_depth during a read and 0 otherwise so the
    // header word is always waiting at the BRAM output
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bram_addr <= '0;
        end else if (read_en && (read_cnt <= real_depth)) begin
            bram_addr <= read_cnt;
        end else begin
            bram_addr <= '0;
        end
    end

    always_ff @(posedge clk) begin
        bram_word <= bram_data;
    end

    // Word at address a sits on bram_word while read_cnt == a + 3
    assign first_cnt = include_header ? read_lag : read_lag + addr_width_p'(1);
    assign last_cnt  = real_depth + read_lag;

    assign word_valid = read_en && (read_cnt >= first_cnt) && (read_cnt <= last_cnt);
    assign word_data  = bram_word;

    // One count past the last word
    assign write_done = read_en && (read_cnt == last_cnt + addr_width_p'(1));

endmodule

//--- unpack/header_decoder.sv
`timescale 1ns/1ns

module header_decoder (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                header_load,
    input  logic                                param_clear,
    input  logic [unpacket_pkg::word_width_p-1:0] bram_word,
    output unpacket_pkg::route_e                route,
    output logic [unpacket_pkg::addr_width_p-1:0] real_depth,
    output logic                                include_header
);

    import unpacket_pkg::*;

    logic [word_width_p-1:0] header_q;
    packet_type_e            packet_type;
    length_code_e            length_code;

    // Header held for the whole packet and cleared between packets
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            header_q <= '0;
        end else if (header_load) begin
            header_q <= bram_word;
        end else if (param_clear) begin
            header_q <= '0;
        end
    end

    assign packet_type = packet_type_e'(header_q[31:28]);
    assign length_code = length_code_e'(header_q[27:24]);

    always_comb begin
        case (length_code)
            LEN_SHORT: real_depth = addr_width_p'(header_q[23:15]);
            LEN_514:   real_depth = addr_width_p'(512);
            LEN_771:   real_depth = addr_width_p'(768);
            default:   real_depth = addr_width_p'(1024);
        endcase
    end

    always_comb begin
        case (packet_type)
            B2A_Z_BASIS_DETECTED:     route = ROUTE_Z;
            B2A_X_BASIS_DETECTED:     route = ROUTE_X;
            B2A_ASK_PARITY:           route = ROUTE_ER;
            B2A_VERIFICATION_HASHTAG: route = ROUTE_ER;
            default:                  route = ROUTE_NONE;
        endcase
    end

    // Reconciliation packets forward their header too
    assign include_header = (route == ROUTE_ER);

endmodule

//--- unpack/unpacket_fsm.sv
`timescale 1ns/1ns

module unpacket_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic msg_ready,
    input  logic net_busy,
    input  logic write_done,
    output logic rx_busy,
    output logic header_load,
    output logic read_en,
    output logic param_clear
);

    import unpacket_pkg::*;

    unpack_state_e state;
    unpack_state_e state_next;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                // Accept only when the network side is free
                if (msg_ready && !net_busy) begin
                    state_next = READ_HEADER;
                end
            end
            // Address 0 is already on the BRAM and still has to
            // pass the two read registers
            READ_HEADER: begin
                state_next = SET_PARAMETER;
            end
            SET_PARAMETER: begin
                state_next = WRITE_PORTS;
            end
            WRITE_PORTS: begin
                if (write_done) begin
                    state_next = UNPACK_DONE;
                end
            end
            UNPACK_DONE: begin
                state_next = WAIT_NEXT;
            end
            WAIT_NEXT: begin
                // Re-arm only once the sender has withdrawn the message
                if (!msg_ready) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    // Moore outputs
    assign rx_busy     = (state != IDLE);
    assign header_load = (state == SET_PARAMETER);
    assign read_en     = (state == WRITE_PORTS);
    assign param_clear = (state == UNPACK_DONE);

endmodule

//--- verilog/basis_router.sv
`timescale 1ns/1ns

module basis_router #(
    parameter int sift_full_count = 96
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  unpacket_pkg::route_e                    route,
    input  logic                                    word_valid,
    input  logic [unpacket_pkg::word_width_p-1:0]   word_data,
    input  logic                                    param_clear,
    input  logic                                    sift_reset,
    output logic                                    z_wr_en,
    output logic [unpacket_pkg::word_width_p-1:0]   z_wr_data,
    output logic                                    x_wr_en,
    output logic [2*unpacket_pkg::word_width_p-1:0] x_wr_data,
    output logic                                    er_wr_en,
    output logic [unpacket_pkg::word_width_p-1:0]   er_wr_data,
    output logic                                    sift_full
);

    import unpacket_pkg::*;

    localparam int count_width = $clog2(sift_full_count + 1);

    logic                    z_hit;
    logic                    x_hit;
    logic                    er_hit;
    logic                    pair_odd;
    logic [word_width_p-1:0] pair_upper;
    logic [count_width-1:0]  sift_cnt;

    assign z_hit  = word_valid && (route == ROUTE_Z);
    assign x_hit  = word_valid && (route == ROUTE_X);
    assign er_hit = word_valid && (route == ROUTE_ER);

    // Write strobes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            z_wr_en  <= 1'b0;
            x_wr_en  <= 1'b0;
            er_wr_en <= 1'b0;
        end else begin
            z_wr_en  <= z_hit;
            x_wr_en  <= x_hit && pair_odd;
            er_wr_en <= er_hit;
        end
    end

    // Write data loaded only with its strobe
    always_ff @(posedge clk) begin
        if (z_hit) begin
            z_wr_data <= word_data;
        end
        if (er_hit) begin
            er_wr_data <= word_data;
        end
        if (x_hit && pair_odd) begin
            x_wr_data <= {pair_upper, word_data};
        end
        if (x_hit && !pair_odd) begin
            pair_upper <= word_data;
        end
    end

    // Half of the X pair currently expected
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pair_odd <= 1'b0;
        end else if (param_clear) begin
            pair_odd <= 1'b0;
        end else if (x_hit) begin
            pair_odd <= !pair_odd;
        end
    end

    // Finished sifting packets held at the limit until sift_reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sift_cnt <= '0;
        end else if (sift_reset) begin
            sift_cnt <= '0;
        end else if (param_clear && (route == ROUTE_Z || route == ROUTE_X) && !sift_full) begin
            sift_cnt <= sift_cnt + count_width'(1);
        end
    end

    assign sift_full = (sift_cnt == count_width'(sift_full_count));

endmodule

//--- verilog/unpacket_top.sv
`timescale 1ns/1ns

module unpacket_top #(
    parameter int sift_full_count = 96
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    msg_ready,
    input  logic                                    net_busy,
    output logic                                    rx_busy,
    input  logic                                    sift_reset,
    output logic                                    sift_full,
    output logic [unpacket_pkg::addr_width_p-1:0]   bram_addr,
    input  logic [unpacket_pkg::word_width_p-1:0]   bram_data,
    output logic                                    z_wr_en,
    output logic [unpacket_pkg::word_width_p-1:0]   z_wr_data,
    output logic                                    x_wr_en,
    output logic [2*unpacket_pkg::word_width_p-1:0] x_wr_data,
    output logic                                    er_wr_en,
    output logic [unpacket_pkg::word_width_p-1:0]   er_wr_data
);

    import unpacket_pkg::*;

    logic                    header_load;
    logic                    read_en;
    logic                    param_clear;
    logic                    write_done;
    route_e                  route;
    logic [addr_width_p-1:0] real_depth;
    logic                    include_header;
    logic [word_width_p-1:0] bram_word;
    logic                    word_valid;
    logic [word_width_p-1:0] word_data;

    unpacket_fsm unpacket_fsm_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .msg_ready   (msg_ready),
        .net_busy    (net_busy),
        .write_done  (write_done),
        .rx_busy     (rx_busy),
        .header_load (header_load),
        .read_en     (read_en),
        .param_clear (param_clear)
    );

    header_decoder header_decoder_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .header_load    (header_load),
        .param_clear    (param_clear),
        .bram_word      (bram_word),
        .route          (route),
        .real_depth     (real_depth),
        .include_header (include_header)
    );

    bram_reader bram_reader_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .read_en        (read_en),
        .param_clear    (param_clear),
        .real_depth     (real_depth),
        .include_header (include_header),
        .bram_addr      (bram_addr),
        .bram_data      (bram_data),
        .bram_word      (bram_word),
        .word_valid     (word_valid),
        .word_data      (word_data),
        .write_done     (write_done)
    );

    basis_router #(
        .sift_full_count (sift_full_count)
    ) basis_router_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .route       (route),
        .word_valid  (word_valid),
        .word_data   (word_data),
        .param_clear (param_clear),
        .sift_reset  (sift_reset),
        .z_wr_en     (z_wr_en),
        .z_wr_data   (z_wr_data),
        .x_wr_en     (x_wr_en),
        .x_wr_data   (x_wr_data),
        .er_wr_en    (er_wr_en),
        .er_wr_data  (er_wr_data),
        .sift_full   (sift_full)
    );

endmodule
